// ==== verilog/vgaPkg.sv ====
package vgaPkg;

	// Frame buffer addressing
	localparam int verticalAddrBits = 7;
	localparam int horizontalAddrBits = 6;
	localparam int memAddrBits = verticalAddrBits + horizontalAddrBits;

	// Five 6-bit pixels are packed into each 32-bit word
	localparam int pixelBits = 6;
	localparam int subPixelMax = 4;

	// Register bus
	localparam int regAddrBits = 12;
	localparam logic [regAddrBits-1:0] regControl = 12'h000;
	localparam logic [regAddrBits-1:0] regHVisible = 12'h010;
	localparam logic [regAddrBits-1:0] regHFrontPorch = 12'h014;
	localparam logic [regAddrBits-1:0] regHSync = 12'h018;
	localparam logic [regAddrBits-1:0] regHWholeLine = 12'h01C;
	localparam logic [regAddrBits-1:0] regVVisible = 12'h020;
	localparam logic [regAddrBits-1:0] regVFrontPorch = 12'h024;
	localparam logic [regAddrBits-1:0] regVSync = 12'h028;
	localparam logic [regAddrBits-1:0] regVWholeLine = 12'h02C;

	typedef logic [10:0] hCount_t;
	typedef logic [9:0] vCount_t;

	typedef struct packed {
		logic we;
		logic oe;
		logic [regAddrBits-1:0] address;
		logic [3:0] byteSelect;
		logic [31:0] writeData;
	} busReq_t;

	typedef struct packed {
		logic readValid;
		logic [31:0] readData;
	} busRsp_t;

	typedef struct packed {
		logic vsyncIrqEnable;
		logic hsyncIrqEnable;
		logic enableOutput;
		logic [3:0] verticalPixelSize;
		logic [3:0] horizontalPixelSize;
	} vgaControl_t;

	typedef struct packed {
		hCount_t hVisibleEnd;
		hCount_t hFrontPorchEnd;
		hCount_t hSyncEnd;
		hCount_t hWholeLineEnd;
		vCount_t vVisibleEnd;
		vCount_t vFrontPorchEnd;
		vCount_t vSyncEnd;
		vCount_t vWholeLineEnd;
	} axisTiming_t;

	typedef struct packed {
		logic inHVisible;
		logic inVVisible;
		logic hVisibleEnd;
		logic hLineEnd;
		logic hsync;
		logic vsync;
	} scanState_t;

	typedef struct packed {
		logic fetch;
		logic [memAddrBits-1:0] address;
	} memReq_t;

	// Control word as seen on the bus; bits 8 and 9 are not implemented
	localparam logic [12:0] controlDefault = 13'h0AA;
	localparam logic [12:0] controlWriteMask = 13'h1CFF;

	// 800 x 600 at 60 Hz
	localparam axisTiming_t timingDefault = '{
		hVisibleEnd: 11'd799,
		hFrontPorchEnd: 11'd839,
		hSyncEnd: 11'd967,
		hWholeLineEnd: 11'd1055,
		vVisibleEnd: 10'd599,
		vFrontPorchEnd: 10'd600,
		vSyncEnd: 10'd604,
		vWholeLineEnd: 10'd627
	};

endpackage

// ==== verilog/vgaConfigRegs.sv ====
`timescale 1ns/1ps

module vgaConfigRegs (
	input logic vga_clk,
	input logic rst,
	input vgaPkg::busReq_t bus,
	output vgaPkg::busRsp_t busRsp,
	output vgaPkg::vgaControl_t control,
	output vgaPkg::axisTiming_t timing
);
	import vgaPkg::*;

	logic [12:0] controlBits;
	axisTiming_t timingRegs;
	logic readValid;
	logic [31:0] readData;
	logic [31:0] readMux;

	// Replace the byte lanes picked by byteSelect with the bus write data
	function automatic logic [31:0] laneMerge(input logic [31:0] current);
		logic [31:0] merged;
		merged = current;
		for (int i = 0; i < 4; i++) begin
			if (bus.byteSelect[i])
				merged[8*i +: 8] = bus.writeData[8*i +: 8];
		end
		return merged;
	endfunction

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			controlBits <= controlDefault;
			timingRegs <= timingDefault;
		end else if (bus.we) begin
			case (bus.address)
				regControl:
					controlBits <= 13'(laneMerge(32'(controlBits))) & controlWriteMask;
				regHVisible:
					timingRegs.hVisibleEnd <= hCount_t'(laneMerge(32'(timingRegs.hVisibleEnd)));
				regHFrontPorch:
					timingRegs.hFrontPorchEnd <= hCount_t'(laneMerge(32'(timingRegs.hFrontPorchEnd)));
				regHSync:
					timingRegs.hSyncEnd <= hCount_t'(laneMerge(32'(timingRegs.hSyncEnd)));
				regHWholeLine:
					timingRegs.hWholeLineEnd <= hCount_t'(laneMerge(32'(timingRegs.hWholeLineEnd)));
				regVVisible:
					timingRegs.vVisibleEnd <= vCount_t'(laneMerge(32'(timingRegs.vVisibleEnd)));
				regVFrontPorch:
					timingRegs.vFrontPorchEnd <= vCount_t'(laneMerge(32'(timingRegs.vFrontPorchEnd)));
				regVSync:
					timingRegs.vSyncEnd <= vCount_t'(laneMerge(32'(timingRegs.vSyncEnd)));
				regVWholeLine:
					timingRegs.vWholeLineEnd <= vCount_t'(laneMerge(32'(timingRegs.vWholeLineEnd)));
				default: ;
			endcase
		end
	end

	// Unmapped offsets read as all ones
	always_comb begin
		case (bus.address)
			regControl: readMux = 32'(controlBits);
			regHVisible: readMux = 32'(timingRegs.hVisibleEnd);
			regHFrontPorch: readMux = 32'(timingRegs.hFrontPorchEnd);
			regHSync: readMux = 32'(timingRegs.hSyncEnd);
			regHWholeLine: readMux = 32'(timingRegs.hWholeLineEnd);
			regVVisible: readMux = 32'(timingRegs.vVisibleEnd);
			regVFrontPorch: readMux = 32'(timingRegs.vFrontPorchEnd);
			regVSync: readMux = 32'(timingRegs.vSyncEnd);
			regVWholeLine: readMux = 32'(timingRegs.vWholeLineEnd);
			default: readMux = '1;
		endcase
	end

	always_ff @(posedge vga_clk) begin
		if (rst)
			readValid <= 1'b0;
		else
			readValid <= bus.oe;
	end

	always_ff @(posedge vga_clk) begin
		if (bus.oe)
			readData <= readMux;
	end

	assign busRsp.readValid = readValid;
	assign busRsp.readData = readData;

	assign control.vsyncIrqEnable = controlBits[12];
	assign control.hsyncIrqEnable = controlBits[11];
	assign control.enableOutput = controlBits[10];
	assign control.verticalPixelSize = controlBits[7:4];
	assign control.horizontalPixelSize = controlBits[3:0];
	assign timing = timingRegs;

endmodule

// ==== verilog/syncTimingGen.sv ====
`timescale 1ns/1ps

module syncTimingGen (
	input logic vga_clk,
	input logic rst,
	input logic enable,
	input vgaPkg::axisTiming_t timing,
	output vgaPkg::scanState_t scan
);
	import vgaPkg::*;

	hCount_t hCount;
	vCount_t vCount;
	logic inHVisible;
	logic inVVisible;
	logic hsync;
	logic vsync;

	logic hVisibleEnd;
	logic hFrontPorchEnd;
	logic hSyncEnd;
	logic hLineEnd;
	logic vVisibleEnd;
	logic vFrontPorchEnd;
	logic vSyncEnd;
	logic vFrameEnd;

	assign hVisibleEnd = hCount == timing.hVisibleEnd;
	assign hFrontPorchEnd = hCount == timing.hFrontPorchEnd;
	assign hSyncEnd = hCount == timing.hSyncEnd;
	assign hLineEnd = hCount == timing.hWholeLineEnd;

	assign vVisibleEnd = vCount == timing.vVisibleEnd;
	assign vFrontPorchEnd = vCount == timing.vFrontPorchEnd;
	assign vSyncEnd = vCount == timing.vSyncEnd;
	assign vFrameEnd = vCount == timing.vWholeLineEnd;

	// Horizontal axis steps every pixel clock
	always_ff @(posedge vga_clk) begin
		if (rst || !enable) begin
			hCount <= '0;
			inHVisible <= 1'b1;
			hsync <= 1'b1;
		end else begin
			hCount <= hLineEnd ? '0 : hCount + 11'd1;
			if (hVisibleEnd)
				inHVisible <= 1'b0;
			else if (hLineEnd)
				inHVisible <= 1'b1;
			if (hFrontPorchEnd)
				hsync <= 1'b0;
			else if (hSyncEnd)
				hsync <= 1'b1;
		end
	end

	// Vertical axis steps once per line
	always_ff @(posedge vga_clk) begin
		if (rst || !enable) begin
			vCount <= '0;
			inVVisible <= 1'b1;
			vsync <= 1'b1;
		end else if (hLineEnd) begin
			vCount <= vFrameEnd ? '0 : vCount + 10'd1;
			if (vVisibleEnd)
				inVVisible <= 1'b0;
			else if (vFrameEnd)
				inVVisible <= 1'b1;
			if (vFrontPorchEnd)
				vsync <= 1'b0;
			else if (vSyncEnd)
				vsync <= 1'b1;
		end
	end

	assign scan.inHVisible = inHVisible;
	assign scan.inVVisible = inVVisible;
	assign scan.hVisibleEnd = enable && hVisibleEnd;
	assign scan.hLineEnd = enable && hLineEnd;
	assign scan.hsync = hsync;
	assign scan.vsync = vsync;

endmodule

// ==== verilog/pixelAddressGen.sv ====
`timescale 1ns/1ps

module pixelAddressGen (
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaControl_t control,
	input vgaPkg::scanState_t scan,
	output vgaPkg::memReq_t memReq,
	output logic [2:0] subPixel
);
	import vgaPkg::*;

	logic [3:0] hStretch;
	logic [3:0] hStretchNext;
	logic [3:0] vStretch;
	logic [3:0] vStretchNext;
	logic [2:0] subCount;
	logic [2:0] subCountNext;
	logic [horizontalAddrBits-3:0] column;
	logic [horizontalAddrBits-3:0] columnNext;
	logic [verticalAddrBits-1:0] row;
	logic [verticalAddrBits-1:0] rowNext;

	always_comb begin
		hStretchNext = hStretch;
		vStretchNext = vStretch;
		subCountNext = subCount;
		columnNext = column;
		rowNext = row;

		// Outside the visible rows everything rewinds to the frame origin
		if (!control.enableOutput || !scan.inVVisible) begin
			hStretchNext = '0;
			vStretchNext = '0;
			subCountNext = '0;
			columnNext = '0;
			rowNext = '0;
		end else begin
			if (scan.inHVisible) begin
				if (hStretch + 4'd1 == control.horizontalPixelSize) begin
					hStretchNext = '0;
					if (subCount == 3'(subPixelMax)) begin
						subCountNext = '0;
						columnNext = column + 1'b1;
					end else begin
						subCountNext = subCount + 3'd1;
					end
				end else begin
					hStretchNext = hStretch + 4'd1;
				end
			end else begin
				hStretchNext = '0;
				subCountNext = '0;
				columnNext = '0;
			end

			// Row advances once verticalPixelSize lines have been drawn
			if (scan.hVisibleEnd) begin
				if (vStretch + 4'd1 == control.verticalPixelSize) begin
					vStretchNext = '0;
					rowNext = row + 1'b1;
				end else begin
					vStretchNext = vStretch + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			hStretch <= '0;
			vStretch <= '0;
			subCount <= '0;
			column <= '0;
			row <= '0;
			subPixel <= '0;
		end else begin
			hStretch <= hStretchNext;
			vStretch <= vStretchNext;
			subCount <= subCountNext;
			column <= columnNext;
			row <= rowNext;
			// Lines up with the word latched in the output stage
			subPixel <= subCount;
		end
	end

	// Address from the next counter values so data returns a cycle after the step
	assign memReq.fetch = control.enableOutput && (rowNext != row || columnNext != column);
	assign memReq.address = {rowNext, columnNext, 2'b00};

endmodule

// ==== verilog/videoOutputStage.sv ====
`timescale 1ns/1ps

module videoOutputStage (
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaControl_t control,
	input vgaPkg::scanState_t scan,
	input logic fetch,
	input logic [31:0] memData,
	input logic [2:0] subPixel,
	output logic [1:0] vgaR,
	output logic [1:0] vgaG,
	output logic [1:0] vgaB,
	output logic vgaHsync,
	output logic vgaVsync,
	output logic [1:0] vgaIrq
);
	import vgaPkg::*;

	logic loadWord;
	logic [subPixelMax:0][pixelBits-1:0] pixelWord;
	logic [pixelBits-1:0] pixel;
	logic onScreen;
	logic lastHsync;
	logic lastVsync;

	// Memory data is valid the cycle after fetch
	always_ff @(posedge vga_clk) begin
		if (rst)
			loadWord <= 1'b0;
		else
			loadWord <= fetch;
	end

	always_ff @(posedge vga_clk) begin
		if (loadWord)
			pixelWord <= memData[(subPixelMax+1)*pixelBits-1:0];
	end

	assign pixel = (subPixel <= 3'(subPixelMax)) ? pixelWord[subPixel] : pixelWord[0];
	assign onScreen = control.enableOutput && scan.inHVisible && scan.inVVisible;

	// Red sits in the low bits of each pixel
	assign vgaR = onScreen ? pixel[1:0] : 2'b00;
	assign vgaG = onScreen ? pixel[3:2] : 2'b00;
	assign vgaB = onScreen ? pixel[5:4] : 2'b00;

	assign vgaHsync = control.enableOutput ? scan.hsync : 1'b1;
	assign vgaVsync = control.enableOutput ? scan.vsync : 1'b1;

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			lastHsync <= 1'b1;
			lastVsync <= 1'b1;
		end else begin
			lastHsync <= vgaHsync;
			lastVsync <= vgaVsync;
		end
	end

	// Falling sync edge gives a one-cycle interrupt pulse
	assign vgaIrq[1] = control.vsyncIrqEnable && lastVsync && !vgaVsync;
	assign vgaIrq[0] = control.hsyncIrqEnable && lastHsync && !vgaHsync;

endmodule

// ==== verilog/vgaController.sv ====
`timescale 1ns/1ps

module vgaController (
	input logic vga_clk,
	input logic rst,
	input vgaPkg::busReq_t bus,
	output vgaPkg::busRsp_t busRsp,
	output vgaPkg::memReq_t memReq,
	input logic [31:0] memData,
	output logic [1:0] vgaR,
	output logic [1:0] vgaG,
	output logic [1:0] vgaB,
	output logic vgaHsync,
	output logic vgaVsync,
	output logic [1:0] vgaIrq
);
	import vgaPkg::*;

	vgaControl_t control;
	axisTiming_t timing;
	scanState_t scan;
	logic [2:0] subPixel;

	vgaConfigRegs configRegs (
		.vga_clk(vga_clk),
		.rst(rst),
		.bus(bus),
		.busRsp(busRsp),
		.control(control),
		.timing(timing)
	);

	syncTimingGen timingGen (
		.vga_clk(vga_clk),
		.rst(rst),
		.enable(control.enableOutput),
		.timing(timing),
		.scan(scan)
	);

	pixelAddressGen addressGen (
		.vga_clk(vga_clk),
		.rst(rst),
		.control(control),
		.scan(scan),
		.memReq(memReq),
		.subPixel(subPixel)
	);

	videoOutputStage outputStage (
		.vga_clk(vga_clk),
		.rst(rst),
		.control(control),
		.scan(scan),
		.fetch(memReq.fetch),
		.memData(memData),
		.subPixel(subPixel),
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB),
		.vgaHsync(vgaHsync),
		.vgaVsync(vgaVsync),
		.vgaIrq(vgaIrq)
	);

endmodule

// ==== dv/vgaController_assert.sv ====
`timescale 1ns/1ps

module vgaController_assert (
	input logic vga_clk,
	input logic rst,
	input vgaPkg::vgaControl_t control,
	input vgaPkg::axisTiming_t timing,
	input vgaPkg::memReq_t memReq,
	input logic [1:0] vgaR,
	input logic [1:0] vgaG,
	input logic [1:0] vgaB,
	input logic vgaHsync,
	input logic vgaVsync,
	input logic [1:0] vgaIrq
);
	import vgaPkg::*;

	// 16 cycles per line with hsync low on counts 12 and 13
	// 6 lines per frame with vsync low on line 4
	localparam axisTiming_t smallTiming = '{
		11'd9, 11'd11, 11'd13, 11'd15, 10'd2, 10'd3, 10'd4, 10'd5
	};

	int failCount = 0;
	logic smallMode;
	logic pixelSizeOne;
	logic visible;
	logic [3:0] refH;
	logic [2:0] refV;
	logic recentValid;
	logic olderValid;
	logic [memAddrBits-1:0] recentAddr;
	logic [memAddrBits-1:0] olderAddr;
	logic [5:0] expectedPixel;
	logic [5:0] rgb;
	logic hsyncExpected;
	logic vsyncExpected;
	logic [1:0] irqExpected;
	logic fetchExpected;
	logic [memAddrBits-1:0] fetchAddrExpected;

	function automatic logic [5:0] addrHash(input logic [memAddrBits-1:0] addr);
		return 6'(addr % 63);
	endfunction

	assign smallMode = control.enableOutput && timing == smallTiming;
	assign pixelSizeOne = control.horizontalPixelSize == 4'd1 && control.verticalPixelSize == 4'd1;
	assign visible = refH <= 4'd9 && refV <= 3'd2;
	assign expectedPixel = addrHash(olderAddr);
	assign rgb = {vgaB, vgaG, vgaR};

	assign hsyncExpected = !(refH == 4'd12 || refH == 4'd13);
	assign vsyncExpected = refV != 3'd4;

	// Interrupts pulse on the first low cycle of each sync
	assign irqExpected[1] = control.vsyncIrqEnable && refV == 3'd4 && refH == 4'd0;
	assign irqExpected[0] = control.hsyncIrqEnable && refH == 4'd12;

	// With pixel size 1 a visible line fetches column 1 after five pixels
	// and the next row at the end of the visible area, line 3 rewinds to the origin
	assign fetchExpected = (refV <= 3'd2 && (refH == 4'd4 || refH == 4'd9 || refH == 4'd10))
		|| (refV == 3'd3 && refH == 4'd0);

	always_comb begin
		fetchAddrExpected = '0;
		if (refV <= 3'd2) begin
			if (refH == 4'd4)
				fetchAddrExpected = {verticalAddrBits'(refV), 4'd1, 2'b00};
			else if (refH == 4'd9)
				fetchAddrExpected = {verticalAddrBits'(refV + 3'd1), 4'd2, 2'b00};
			else if (refH == 4'd10)
				fetchAddrExpected = {verticalAddrBits'(refV + 3'd1), 4'd0, 2'b00};
		end
	end

	// Reference scan position starts at zero on the first enabled cycle
	always_ff @(posedge vga_clk) begin
		if (rst || !smallMode) begin
			refH <= '0;
			refV <= '0;
		end else begin
			refH <= refH + 4'd1;
			if (refH == 4'd15)
				refV <= (refV == 3'd5) ? 3'd0 : refV + 3'd1;
		end
	end

	// olderAddr is the latest fetch issued two or more cycles back
	always_ff @(posedge vga_clk) begin
		if (rst) begin
			recentValid <= 1'b0;
			olderValid <= 1'b0;
		end else begin
			if (memReq.fetch) begin
				recentAddr <= memReq.address;
				recentValid <= 1'b1;
			end
			olderAddr <= recentAddr;
			olderValid <= recentValid;
		end
	end

	assert property (@(posedge vga_clk) disable iff (rst)
		!control.enableOutput |-> vgaHsync && vgaVsync && !memReq.fetch
			&& {vgaR, vgaG, vgaB} == 6'd0 && vgaIrq == 2'b00)
		else begin
			failCount++;
			$error("display not idle while output is disabled");
		end

	assert property (@(posedge vga_clk) disable iff (rst)
		smallMode |-> vgaHsync == hsyncExpected)
		else begin
			failCount++;
			$error("Error in hsync timing: expected %b, actual %b",
				$sampled(hsyncExpected), $sampled(vgaHsync));
		end

	assert property (@(posedge vga_clk) disable iff (rst)
		smallMode |-> vgaVsync == vsyncExpected)
		else begin
			failCount++;
			$error("Error in vsync timing: expected %b, actual %b",
				$sampled(vsyncExpected), $sampled(vgaVsync));
		end

	assert property (@(posedge vga_clk) disable iff (rst)
		smallMode && !visible |-> rgb == 6'd0)
		else begin
			failCount++;
			$error("Error in blanking: expected 0x00, actual 0x%02h", $sampled(rgb));
		end

	assert property (@(posedge vga_clk) disable iff (rst)
		smallMode && pixelSizeOne && olderValid && visible && refH >= 4'd2
			|-> rgb == expectedPixel)
		else begin
			failCount++;
			$error("Error in pixel data: expected 0x%02h, actual 0x%02h",
				$sampled(expectedPixel), $sampled(rgb));
		end

	assert property (@(posedge vga_clk) disable iff (rst)
		smallMode && pixelSizeOne |-> memReq.fetch == fetchExpected
			&& (!memReq.fetch || memReq.address == fetchAddrExpected))
		else begin
			failCount++;
			$error("Error in fetch: expected %b at 0x%04h, actual %b at 0x%04h",
				$sampled(fetchExpected), $sampled(fetchAddrExpected),
				$sampled(memReq.fetch), $sampled(memReq.address));
		end

	assert property (@(posedge vga_clk) disable iff (rst)
		smallMode |-> vgaIrq == irqExpected)
		else begin
			failCount++;
			$error("Error in sync interrupt: expected %b, actual %b",
				$sampled(irqExpected), $sampled(vgaIrq));
		end

endmodule

bind vgaController vgaController_assert checks (
	.vga_clk(vga_clk),
	.rst(rst),
	.control(control),
	.timing(timing),
	.memReq(memReq),
	.vgaR(vgaR),
	.vgaG(vgaG),
	.vgaB(vgaB),
	.vgaHsync(vgaHsync),
	.vgaVsync(vgaVsync),
	.vgaIrq(vgaIrq)
);

// ==== dv/vgaTb.sv ====
`timescale 1ns/1ps

module vgaTb;
	import vgaPkg::*;

	localparam logic [regAddrBits-1:0] regOffset [9] = '{
		regControl, regHVisible, regHFrontPorch, regHSync, regHWholeLine,
		regVVisible, regVFrontPorch, regVSync, regVWholeLine
	};
	localparam logic [31:0] regMask [9] = '{
		32'h1CFF, 32'h7FF, 32'h7FF, 32'h7FF, 32'h7FF, 32'h3FF, 32'h3FF, 32'h3FF, 32'h3FF
	};
	localparam logic [31:0] resetValue [9] = '{
		32'h0AA, 32'd799, 32'd839, 32'd967, 32'd1055, 32'd599, 32'd600, 32'd604, 32'd627
	};

	logic vga_clk;
	logic rst;
	busReq_t bus;
	busRsp_t busRsp;
	memReq_t memReq;
	logic [31:0] memData;
	logic [1:0] vgaR;
	logic [1:0] vgaG;
	logic [1:0] vgaB;
	logic vgaHsync;
	logic vgaVsync;
	logic [1:0] vgaIrq;

	logic [31:0] regExpected [9];
	logic fetchSeen;
	logic [memAddrBits-1:0] fetchAddr;

	vgaController dut (.*);

	initial begin
		vga_clk = 1'b0;
		forever #10 vga_clk = ~vga_clk;
	end

	function automatic logic [5:0] addrHash(input logic [memAddrBits-1:0] addr);
		return 6'(addr % 63);
	endfunction

	function automatic logic [31:0] mergeLanes(input logic [31:0] current,
		input logic [31:0] data, input logic [3:0] lanes);
		logic [31:0] merged;
		merged = current;
		for (int lane = 0; lane < 4; lane++) begin
			if (lanes[lane])
				merged[lane*8 +: 8] = data[lane*8 +: 8];
		end
		return merged;
	endfunction

	task automatic stopRun(input string reason);
		$display("Test failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error in %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
			stopRun("register read-back mismatch");
		end
	endtask

	// Frame memory, fetch sampled mid-cycle and answered in the next cycle
	always @(negedge vga_clk) begin
		fetchSeen <= memReq.fetch;
		fetchAddr <= memReq.address;
	end

	initial begin
		memData = '0;
		forever begin
			@(posedge vga_clk);
			#2;
			if (fetchSeen)
				memData = {2'b00, {5{addrHash(fetchAddr)}}};
		end
	end

	always @(negedge vga_clk) begin
		if (dut.checks.failCount != 0)
			stopRun("a concurrent assertion in the bound checker failed");
	end

	task automatic writeReg(input logic [regAddrBits-1:0] offset, input logic [31:0] data,
		input logic [3:0] lanes);
		@(posedge vga_clk);
		#2;
		bus.we = 1'b1;
		bus.address = offset;
		bus.byteSelect = lanes;
		bus.writeData = data;
		@(posedge vga_clk);
		#2;
		bus.we = 1'b0;
	endtask

	task automatic readReg(input logic [regAddrBits-1:0] offset, output logic [31:0] data);
		int waited;
		@(posedge vga_clk);
		#2;
		bus.oe = 1'b1;
		bus.address = offset;
		@(posedge vga_clk);
		#2;
		bus.oe = 1'b0;
		waited = 0;
		while (!busRsp.readValid) begin
			if (waited == 8)
				stopRun("no read response within 8 cycles");
			waited++;
			@(posedge vga_clk);
			#2;
		end
		data = busRsp.readData;
	endtask

	task automatic checkReg(input int index, input string phase);
		logic [31:0] readBack;
		readReg(regOffset[index], readBack);
		checkValue($sformatf("%s at offset 0x%03h", phase, regOffset[index]),
			regExpected[index], readBack);
	endtask

	initial begin
		logic [31:0] data;
		logic [31:0] readBack;
		logic [3:0] lanes;
		void'($urandom(32'h1d4b));
		bus = '0;
		rst = 1'b1;
		repeat (2) @(posedge vga_clk);
		#2;
		rst = 1'b0;

		foreach (regExpected[i]) begin
			regExpected[i] = resetValue[i];
			checkReg(i, "reset default");
		end

		// Random data with mixed byte lanes
		for (int round = 0; round < 3; round++) begin
			foreach (regExpected[i]) begin
				data = $urandom;
				lanes = 4'($urandom);
				writeReg(regOffset[i], data, lanes);
				regExpected[i] = mergeLanes(regExpected[i], data, lanes) & regMask[i];
				checkReg(i, "merged write");
			end
		end
		readReg(12'h030, readBack);
		checkValue("unmapped offset", 32'hFFFF_FFFF, readBack);

		writeReg(regControl, 32'h0, 4'hF);
		repeat (50) @(posedge vga_clk);

		// Timing is changed only while the output is off
		writeReg(regHVisible, 32'd9, 4'hF);
		writeReg(regHFrontPorch, 32'd11, 4'hF);
		writeReg(regHSync, 32'd13, 4'hF);
		writeReg(regHWholeLine, 32'd15, 4'hF);
		writeReg(regVVisible, 32'd2, 4'hF);
		writeReg(regVFrontPorch, 32'd3, 4'hF);
		writeReg(regVSync, 32'd4, 4'hF);
		writeReg(regVWholeLine, 32'd5, 4'hF);

		// Enable with pixel sizes of 1, then step through the irq enables
		writeReg(regControl, 32'h1C11, 4'hF);
		repeat (3 * 96) @(posedge vga_clk);
		writeReg(regControl, 32'h0C11, 4'hF);
		repeat (2 * 96) @(posedge vga_clk);
		writeReg(regControl, 32'h1411, 4'hF);
		repeat (2 * 96) @(posedge vga_clk);
		writeReg(regControl, 32'h0411, 4'hF);
		repeat (2 * 96) @(posedge vga_clk);
		writeReg(regControl, 32'h0, 4'hF);
		repeat (20) @(posedge vga_clk);

		if (dut.checks.failCount == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			stopRun("concurrent assertion failures were recorded");
		end
	end

endmodule

// ==== filelist.f ====
verilog/vgaPkg.sv
verilog/vgaConfigRegs.sv
verilog/syncTimingGen.sv
verilog/pixelAddressGen.sv
verilog/videoOutputStage.sv
verilog/vgaController.sv
dv/vgaController_assert.sv
dv/vgaTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the VGA controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f --top-module vgaTb -o vgaSim; then
	echo "Verilator build failed"
	exit 1
fi

# A high error limit lets the testbench see failed assertions and report them
output=$(./obj_dir/vgaSim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
